// File: build.f
hw/config_pkg.sv
hw/config_deserializer.sv
hw/config_node.sv
hw/config_net_top.sv
test/config_node_sva.sv
test/config_net_tb.sv

// File: test/config_testdata.txt
# test_name node_id opcode data, all hex, opcode 0 nop 1 write 2 default 3 reserved
# then expected data0_o data1_o data2_o, names starting b2b follow the previous packet directly
reset_values      00 0 0000 a5 3c0 beef
wr_node0          01 1 1234 34 3c0 beef
wr_node1          02 1 5678 34 678 beef
wr_node2          07 1 cafe 34 678 cafe
foreign_id_09     09 1 ffff 34 678 cafe
nop_node0         01 0 0000 34 678 cafe
rsvd_node2        07 3 1111 34 678 cafe
default_node1     02 2 9999 34 3c0 cafe
b2b_wr_node1      02 1 0abc 34 abc cafe
b2b_wr_node0      01 1 ff5a 5a abc cafe
default_node2     07 2 0000 5a abc beef
bcast_write       ff 1 c3d2 d2 3d2 c3d2
b2b_nop_bcast     ff 0 0000 d2 3d2 c3d2
b2b_rsvd_bcast    ff 3 7777 d2 3d2 c3d2
foreign_id_00     00 1 4444 d2 3d2 c3d2
bcast_default     ff 2 1357 a5 3c0 beef
wr_node2_b        07 1 0001 a5 3c0 0001
b2b_wr_node0_b    01 1 8001 01 3c0 0001
b2b_wr_node1_b    02 1 fedc 01 edc 0001
foreign_id_fe     fe 1 2222 01 edc 0001
b2b_default_node0 01 2 0000 a5 edc 0001
bcast_write_b     ff 1 0f0f 0f f0f 0f0f

// File: test/config_net_tb.sv
`timescale 1ns/1ps
`default_nettype none

module config_net_tb;

   import config_pkg::*;

   localparam int max_gap_lp   = 64; // longest run of extra cycles the serializer may insert
   localparam int max_tests_lp = 64;

   logic        clk_dst;
   logic        rst_n;
   logic        cfg_valid;
   logic        cfg_bit;
   logic [7:0]  data0;
   logic [11:0] data1;
   logic [15:0] data2;

   logic [15:0] lfsr_r;
   int          pass_count;
   int          fail_count;
   int          error_count;

   // one entry per data file line, packet bits and expected outputs packed
   int                      num_tests;
   string                   test_names [max_tests_lp];
   logic [cfg_pkt_bits-1:0] test_pkt   [max_tests_lp];
   logic [35:0]             test_exp   [max_tests_lp]; // {data0, data1, data2}

   // output check that falls due two rising edges after the last packet bit
   logic check_pending;
   int   check_wait;
   int   check_idx;

   config_net_top config_net_top_i (
      .clk_dst_i   (clk_dst),
      .rst_n_i     (rst_n),
      .cfg_valid_i (cfg_valid),
      .cfg_bit_i   (cfg_bit),
      .data0_o     (data0),
      .data1_o     (data1),
      .data2_o     (data2)
   );

   initial begin
      clk_dst = 1'b0;
      forever begin
         #5 clk_dst = ~clk_dst;
      end
   end

   // Galois form of x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 16'hB400;
      end
      return state >> 1;
   endfunction

   task automatic take_random_bit(output logic b);
      b      = lfsr_r[0];
      lfsr_r = lfsr_next(lfsr_r);
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $finish;
   endtask

   task automatic check_data8(input string sig, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s got %h, expected %h", $time, sig, got, exp);
         error_count++;
      end
   endtask

   task automatic check_data12(input string sig, input logic [11:0] got, input logic [11:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s got %h, expected %h", $time, sig, got, exp);
         error_count++;
      end
   endtask

   task automatic check_data16(input string sig, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s got %h, expected %h", $time, sig, got, exp);
         error_count++;
      end
   endtask

   task automatic check_outputs(input int idx);
      int errors_before;
      errors_before = error_count;
      check_data8("data0_o", data0, test_exp[idx][35:28]);
      check_data12("data1_o", data1, test_exp[idx][27:16]);
      check_data16("data2_o", data2, test_exp[idx][15:0]);
      if (error_count == errors_before) begin
         pass_count++;
         $display("test %s: ok", test_names[idx]);
      end else begin
         fail_count++;
         $display("test %s: mismatch", test_names[idx]);
      end
   endtask

   // called on a falling edge, returns on the next falling edge with the strobe dropped
   task automatic strobe_bit(input logic b);
      cfg_valid = 1'b1;
      cfg_bit   = b;
      @(posedge clk_dst);
      @(negedge clk_dst);
      cfg_valid = 1'b0;
      cfg_bit   = 1'b1;
   endtask

   task automatic random_gap();
      logic more;
      int   gap;
      gap = 0;
      take_random_bit(more);
      while (more) begin
         @(negedge clk_dst); // a cycle without a strobe
         gap++;
         if (gap > max_gap_lp) begin
            abort_run("serializer stalled, a strobe gap ran past 64 cycles");
         end
         take_random_bit(more);
      end
   endtask

   task automatic leading_idle();
      logic more;
      int   count;
      count = 0;
      take_random_bit(more);
      while (more) begin
         strobe_bit(1'b1); // idle level, the deserializer has to skip it
         count++;
         if (count > max_gap_lp) begin
            abort_run("serializer stalled while sending idle bits");
         end
         take_random_bit(more);
      end
   endtask

   task automatic send_packet(input int idx);
      strobe_bit(1'b0);
      random_gap();
      for (int i = cfg_pkt_bits - 1; i >= 0; i--) begin
         if (i == 0) begin
            check_idx     = idx;
            check_wait    = 2;
            check_pending = 1'b1; // armed before the edge that samples the last bit
         end
         strobe_bit(test_pkt[idx][i]);
         if (i != 0) begin
            random_gap();
         end
      end
   endtask

   always @(posedge clk_dst) begin
      if (check_wait > 0) begin
         check_wait = check_wait - 1;
      end
   end

   // outputs are sampled on the falling edge, half a cycle away from any update
   always @(negedge clk_dst) begin
      if (check_pending && check_wait == 0) begin
         check_outputs(check_idx);
         check_pending = 1'b0;
      end
   end

   initial begin
      int               fd;
      int               fields;
      int               wait_count;
      logic [8*160-1:0] line_buf;
      string            name;
      logic [7:0]       id;
      logic [1:0]       op;
      logic [15:0]      data;
      logic [7:0]       exp0;
      logic [11:0]      exp1;
      logic [15:0]      exp2;
      logic             assert_fail;
      rst_n         = 1'b0;
      cfg_valid     = 1'b0;
      cfg_bit       = 1'b1;
      lfsr_r        = 16'd26753;
      pass_count    = 0;
      fail_count    = 0;
      error_count   = 0;
      num_tests     = 0;
      check_pending = 1'b0;
      check_wait    = 0;
      check_idx     = 0;

      fd = $fopen("test/config_testdata.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open test/config_testdata.txt");
      end else begin
         while (!$feof(fd) && num_tests < max_tests_lp) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) != 0) begin
               fields = $sscanf(line_buf, "%s %h %h %h %h %h %h",
                                name, id, op, data, exp0, exp1, exp2);
               if (fields == 7) begin // comment and blank lines fall out here
                  test_names[num_tests] = name;
                  test_pkt[num_tests]   = {id, cfg_op_e'(op), data};
                  test_exp[num_tests]   = {exp0, exp1, exp2};
                  num_tests++;
               end
            end
         end
         $fclose(fd);
      end

      repeat (5) @(posedge clk_dst);
      @(negedge clk_dst);
      rst_n = 1'b1;
      @(negedge clk_dst);

      for (int t = 0; t < num_tests; t++) begin
         if (test_names[t] == "reset_values") begin
            check_outputs(t);
         end else begin
            if (test_names[t].substr(0, 2) != "b2b") begin
               random_gap();
               leading_idle();
            end
            send_packet(t);
         end
      end

      wait_count = 0;
      while (check_pending) begin
         @(negedge clk_dst);
         wait_count++;
         if (wait_count > 10) begin
            abort_run("timed out waiting for the last output check");
         end
      end

      // the bound node checkers flag their own failures
      assert_fail = config_net_top_i.node0_i.node_sva_i.fail_seen
                  | config_net_top_i.node1_i.node_sva_i.fail_seen
                  | config_net_top_i.node2_i.node_sva_i.fail_seen;
      if (assert_fail) begin
         $display("a bound node assertion failed during the run");
      end

      $display("%0d tests passed, %0d failed, %0d output mismatches",
               pass_count, fail_count, error_count);
      if (fail_count == 0 && num_tests > 0 && !assert_fail) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule : config_net_tb

`default_nettype wire

// File: test/config_node_sva.sv
`timescale 1ns/1ps
`default_nettype none

module config_node_sva #(
   parameter logic [config_pkg::cfg_id_bits-1:0] node_id_p   = 8'h01,
   parameter int                                 data_bits_p = 8,
   parameter logic [data_bits_p-1:0]             reset_val_p = '0
) (
   input logic                                 clk_dst_i,
   input logic                                 rst_n_i,
   input logic                                 pkt_v_i,
   input logic [config_pkg::cfg_id_bits-1:0]   pkt_id_i,
   input config_pkg::cfg_op_e                  pkt_op_i,
   input logic [config_pkg::cfg_data_bits-1:0] pkt_data_i,
   input logic [data_bits_p-1:0]               data_o
);

   import config_pkg::*;

   logic                   id_hit;  // a decoded packet addressed to this node or to all nodes
   logic [data_bits_p-1:0] data_lo; // the part of the data field that fits this node
   logic                   fail_seen = 1'b0; // set once any assertion below has failed

   assign id_hit  = pkt_v_i & ((pkt_id_i == node_id_p) | (pkt_id_i == cfg_bcast_id));
   assign data_lo = pkt_data_i[data_bits_p-1:0];

   // the register must come out of reset holding its parameter value
   reset_value_a : assert property (@(posedge clk_dst_i) $rose(rst_n_i) |-> data_o == reset_val_p)
      else begin
         $error("%m: data_o is not the reset value after reset");
         fail_seen = 1'b1;
      end

   // any change has to be caused by a matching packet one cycle earlier
   change_needs_hit_a : assert property (@(posedge clk_dst_i) disable iff (!rst_n_i)
      !$stable(data_o) |-> $past(id_hit))
      else begin
         $error("%m: data_o changed without a matching packet");
         fail_seen = 1'b1;
      end

   // a matching write shows up one cycle later, cut down to the node width
   write_lands_a : assert property (@(posedge clk_dst_i) disable iff (!rst_n_i)
      id_hit && pkt_op_i == CFG_WRITE |=> data_o == $past(data_lo))
      else begin
         $error("%m: data_o does not hold the written data");
         fail_seen = 1'b1;
      end

   default_lands_a : assert property (@(posedge clk_dst_i) disable iff (!rst_n_i)
      id_hit && pkt_op_i == CFG_DEFAULT |=> data_o == reset_val_p)
      else begin
         $error("%m: data_o did not return to the reset value");
         fail_seen = 1'b1;
      end

   known_a : assert property (@(posedge clk_dst_i) disable iff (!rst_n_i) !$isunknown(data_o))
      else begin
         $error("%m: data_o has unknown bits");
         fail_seen = 1'b1;
      end

endmodule : config_node_sva

bind config_node config_node_sva #(
   .node_id_p   (node_id_p),
   .data_bits_p (data_bits_p),
   .reset_val_p (reset_val_p)
) node_sva_i (
   .clk_dst_i  (clk_dst_i),
   .rst_n_i    (rst_n_i),
   .pkt_v_i    (pkt_v_i),
   .pkt_id_i   (pkt_id_i),
   .pkt_op_i   (pkt_op_i),
   .pkt_data_i (pkt_data_i),
   .data_o     (data_o)
);

`default_nettype wire

// File: hw/config_net_top.sv
`timescale 1ns/1ps
`default_nettype none

module config_net_top #(
   // node 0
   parameter logic [config_pkg::cfg_id_bits-1:0] node0_id_p    = 8'd1,
   parameter int                                 node0_bits_p  = 8,
   parameter logic [node0_bits_p-1:0]            node0_reset_p = 8'hA5,
   // node 1
   parameter logic [config_pkg::cfg_id_bits-1:0] node1_id_p    = 8'd2,
   parameter int                                 node1_bits_p  = 12,
   parameter logic [node1_bits_p-1:0]            node1_reset_p = 12'h3C0,
   // node 2
   parameter logic [config_pkg::cfg_id_bits-1:0] node2_id_p    = 8'd7,
   parameter int                                 node2_bits_p  = 16,
   parameter logic [node2_bits_p-1:0]            node2_reset_p = 16'hBEEF
) (
   input  logic                    clk_dst_i,
   input  logic                    rst_n_i,
   input  logic                    cfg_valid_i,
   input  logic                    cfg_bit_i,
   output logic [node0_bits_p-1:0] data0_o,
   output logic [node1_bits_p-1:0] data1_o,
   output logic [node2_bits_p-1:0] data2_o
);

   import config_pkg::*;

   // decoded packet, shared by all nodes
   logic                     pkt_v;
   logic [cfg_id_bits-1:0]   pkt_id;
   cfg_op_e                  pkt_op;
   logic [cfg_data_bits-1:0] pkt_data;

   config_deserializer deserializer_i (
      .clk_dst_i   (clk_dst_i),
      .rst_n_i     (rst_n_i),
      .cfg_valid_i (cfg_valid_i),
      .cfg_bit_i   (cfg_bit_i),
      .pkt_v_o     (pkt_v),
      .pkt_id_o    (pkt_id),
      .pkt_op_o    (pkt_op),
      .pkt_data_o  (pkt_data)
   );

   config_node #(
      .node_id_p   (node0_id_p),
      .data_bits_p (node0_bits_p),
      .reset_val_p (node0_reset_p)
   ) node0_i (
      .clk_dst_i  (clk_dst_i),
      .rst_n_i    (rst_n_i),
      .pkt_v_i    (pkt_v),
      .pkt_id_i   (pkt_id),
      .pkt_op_i   (pkt_op),
      .pkt_data_i (pkt_data),
      .data_o     (data0_o)
   );

   config_node #(
      .node_id_p   (node1_id_p),
      .data_bits_p (node1_bits_p),
      .reset_val_p (node1_reset_p)
   ) node1_i (
      .clk_dst_i  (clk_dst_i),
      .rst_n_i    (rst_n_i),
      .pkt_v_i    (pkt_v),
      .pkt_id_i   (pkt_id),
      .pkt_op_i   (pkt_op),
      .pkt_data_i (pkt_data),
      .data_o     (data1_o)
   );

   // widest node, takes the full data field
   config_node #(
      .node_id_p   (node2_id_p),
      .data_bits_p (node2_bits_p),
      .reset_val_p (node2_reset_p)
   ) node2_i (
      .clk_dst_i  (clk_dst_i),
      .rst_n_i    (rst_n_i),
      .pkt_v_i    (pkt_v),
      .pkt_id_i   (pkt_id),
      .pkt_op_i   (pkt_op),
      .pkt_data_i (pkt_data),
      .data_o     (data2_o)
   );

endmodule : config_net_top

`default_nettype wire

// File: hw/config_node.sv
`timescale 1ns/1ps
`default_nettype none

module config_node #(
   parameter logic [config_pkg::cfg_id_bits-1:0] node_id_p   = 8'h01,
   parameter int                                 data_bits_p = 8,
   parameter logic [data_bits_p-1:0]             reset_val_p = '0
) (
   input  logic                                 clk_dst_i,
   input  logic                                 rst_n_i,
   input  logic                                 pkt_v_i,
   input  logic [config_pkg::cfg_id_bits-1:0]   pkt_id_i,
   input  config_pkg::cfg_op_e                  pkt_op_i,
   input  logic [config_pkg::cfg_data_bits-1:0] pkt_data_i,
   output logic [data_bits_p-1:0]               data_o
);

   import config_pkg::*;

   logic                   id_hit;    // this packet is meant for us
   logic [data_bits_p-1:0] data_r;
   logic [data_bits_p-1:0] data_n;

   // broadcast packets reach every node alongside the addressed ones
   assign id_hit = pkt_v_i & ((pkt_id_i == node_id_p) | (pkt_id_i == cfg_bcast_id));

   always_comb begin
      data_n = data_r;
      if (id_hit) begin
         case (pkt_op_i)
            CFG_WRITE: begin
               // narrow nodes keep only the low bits of the data field
               data_n = pkt_data_i[data_bits_p-1:0];
            end
            CFG_DEFAULT: begin
               data_n = reset_val_p;
            end
            default: begin
               data_n = data_r; // nop and the reserved code both hold
            end
         endcase
      end
   end

   always_ff @(posedge clk_dst_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         data_r <= reset_val_p;
      end else begin
         data_r <= data_n;
      end
   end

   assign data_o = data_r; // new value shows one cycle after the strobe

endmodule : config_node

`default_nettype wire

// File: hw/config_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module config_deserializer (
   input  logic                                 clk_dst_i,
   input  logic                                 rst_n_i,
   input  logic                                 cfg_valid_i,
   input  logic                                 cfg_bit_i,
   output logic                                 pkt_v_o,
   output logic [config_pkg::cfg_id_bits-1:0]   pkt_id_o,
   output config_pkg::cfg_op_e                  pkt_op_o,
   output logic [config_pkg::cfg_data_bits-1:0] pkt_data_o
);

   import config_pkg::*;

   // the counter has to reach cfg_pkt_bits, one past the last bit index
   localparam int cnt_bits_lp = $clog2(cfg_pkt_bits + 1);

   deser_state_e            state_r;
   deser_state_e            state_n;
   logic [cnt_bits_lp-1:0]  cnt_r;   // bits taken so far in this packet
   logic [cfg_pkt_bits-1:0] shift_r; // packet bits, first received at the top
   logic                    start_bit;
   logic                    last_bit;

   // a strobed 0 opens a packet, strobed 1s in between are idle line
   assign start_bit = cfg_valid_i & ~cfg_bit_i;

   // only meaningful while shifting
   assign last_bit = cfg_valid_i & (cnt_r == cnt_bits_lp'(cfg_pkt_bits - 1));

   always_comb begin
      state_n = state_r;
      case (state_r)
         DESER_IDLE: begin
            if (start_bit) begin
               state_n = DESER_SHIFT;
            end
         end
         DESER_SHIFT: begin
            if (last_bit) begin
               state_n = DESER_DONE;
            end
         end
         DESER_DONE: begin
            // the next packet may start right behind this one
            if (start_bit) begin
               state_n = DESER_SHIFT;
            end else begin
               state_n = DESER_IDLE;
            end
         end
         default: begin
            state_n = DESER_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_dst_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r <= DESER_IDLE;
         cnt_r   <= '0;
      end else begin
         state_r <= state_n;
         if (state_r != DESER_SHIFT) begin
            cnt_r <= '0; // rewound before the first data bit can arrive
         end else if (cfg_valid_i) begin
            cnt_r <= cnt_r + 1'b1;
         end
      end
   end

   // The start bit itself is never shifted in, so the fields stay put
   // through DESER_DONE even when a new packet opens in that cycle
   always_ff @(posedge clk_dst_i) begin
      if (state_r == DESER_SHIFT && cfg_valid_i) begin
         shift_r <= {shift_r[cfg_pkt_bits-2:0], cfg_bit_i};
      end
   end

   assign pkt_v_o = (state_r == DESER_DONE); // exactly one cycle per packet

   // id came first so it sits at the top, data came last
   assign pkt_id_o   = shift_r[cfg_pkt_bits-1 -: cfg_id_bits];
   assign pkt_op_o   = cfg_op_e'(shift_r[cfg_data_bits +: cfg_op_bits]);
   assign pkt_data_o = shift_r[cfg_data_bits-1:0];

endmodule : config_deserializer

`default_nettype wire

// File: hw/config_pkg.sv
`default_nettype none

package config_pkg;

   // field sizes of one configuration packet, as sent after the start bit
   localparam int cfg_id_bits   = 8;
   localparam int cfg_op_bits   = 2;
   localparam int cfg_data_bits = 16;

   // id, opcode and data in that order, 26 bits in all
   localparam int cfg_pkt_bits = cfg_id_bits + cfg_op_bits + cfg_data_bits;

   // every node answers to this id as well as to its own
   localparam logic [cfg_id_bits-1:0] cfg_bcast_id = '1;

   // opcodes carried in the packet
   typedef enum logic [cfg_op_bits-1:0] {
      CFG_NOP     = 2'b00, // leave the register alone
      CFG_WRITE   = 2'b01, // load the packet data
      CFG_DEFAULT = 2'b10, // go back to the reset value
      CFG_RSVD    = 2'b11  // reserved, nodes handle it like a nop
   } cfg_op_e;

   // deserializer FSM
   typedef enum logic [1:0] {
      DESER_IDLE  = 2'b00, // waiting for a 0 start bit
      DESER_SHIFT = 2'b01, // collecting the packet bits
      DESER_DONE  = 2'b10  // packet complete, strobe goes out this cycle
   } deser_state_e;

endpackage : config_pkg

`default_nettype wire
